// ==== sources.f ====
src/core_pkg.sv
src/mem_pkg.sv
src/memory_stage.sv
src/mem_controller.sv
src/data_ram.sv
src/mem_timing_regs.sv
src/mem_subsystem.sv
testbench/tb_mem_subsystem.sv

// ==== Makefile ====
# Verilator build and run of the memory subsystem testbench.

VERILATOR ?= verilator
TB_TOP ?= tb_mem_subsystem
RTL_TOP ?= mem_subsystem
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)

run: build
	./$(BUILD_DIR)/$(TB_TOP) | tee $(LOG)
	grep -qxF "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_mem_subsystem.sv ====
`timescale 1ns/100ps

module tb_mem_subsystem;
	import core_pkg::*;
	import mem_pkg::*;

	localparam int RAM_WORDS = 256;
	localparam int WAIT_LIMIT = 200;
	localparam int SEED = 50353;

	logic clk;
	logic rst;
	word_t reg_pc;
	word_t rs2_data;
	word_t alu_out;
	mem_op_t mem_op;
	wb_sel_t wb_sel;
	word_t read_data;
	word_t out_reg_pc;
	word_t out_alu_out;
	wb_sel_t out_wb_sel;
	logic next_flg;
	logic is_stall;
	logic cfg_we;
	cfg_addr_t cfg_addr;
	count_t cfg_wdata;
	count_t cfg_rdata;

	// reference memory with one entry per byte.
	logic [7:0] model [RAM_WORDS*4];

	int errors = 0;
	int monitor_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int load_total = 0;
	int store_total = 0;
	int cur_read_wait = 1;
	int cycle_count = 0;
	int cmd_cycle = 0;
	bit read_pending;
	bit timed_out = 1'b0;

	mem_subsystem #(
		.RAM_WORDS(RAM_WORDS)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.reg_pc(reg_pc),
		.rs2_data(rs2_data),
		.alu_out(alu_out),
		.mem_op(mem_op),
		.wb_sel(wb_sel),
		.read_data(read_data),
		.out_reg_pc(out_reg_pc),
		.out_alu_out(out_alu_out),
		.out_wb_sel(out_wb_sel),
		.next_flg(next_flg),
		.is_stall(is_stall),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ##########################################################################
	// read latency monitor
	// ##########################################################################

	// the edge that raises rdata_valid is one before the edge that first sees it.
	always @(posedge clk) begin
		if (rst) begin
			read_pending = 1'b0;
		end else begin
			if (u_dut.rdata_valid) begin
				assert (read_pending) else begin
					$display("rdata_valid was high without an outstanding read");
					monitor_errors++;
				end
				if (read_pending) begin
					assert (cycle_count - 1 - cmd_cycle == cur_read_wait + 1) else begin
						$display("[FAIL] rdata_valid delay got %h expected %h",
							cycle_count - 1 - cmd_cycle, cur_read_wait + 1);
						monitor_errors++;
					end
				end
				read_pending = 1'b0;
			end
			if (u_dut.cmd == CMD_READ) begin
				read_pending = 1'b1;
				cmd_cycle = cycle_count;
			end
		end
		cycle_count++;
	end

	// ##########################################################################
	// reference model
	// ##########################################################################

	function automatic int byte_index(input word_t addr);
		word_t index;
		index = (addr >> 2) % RAM_WORDS;
		return int'(index) * 4 + int'(addr[1:0]);
	endfunction

	function automatic word_t fill_word(input word_t addr);
		return addr * 32'h9E37_79B1 ^ 32'hC3A5_0F1E;
	endfunction

	// halfword addresses have bit 0 clear and word addresses both low bits.
	function automatic word_t aligned_addr(input mem_op_t op, input word_t addr);
		word_t result;
		result = addr;
		if (op inside {MEM_LH, MEM_LHU, MEM_SH}) begin
			result[0] = 1'b0;
		end else if (op inside {MEM_LW, MEM_SW}) begin
			result[1:0] = 2'b00;
		end
		return result;
	endfunction

	function automatic word_t expected_load(input mem_op_t op, input word_t addr);
		int i;
		i = byte_index(addr);
		case (op)
			MEM_LB: return {{24{model[i][7]}}, model[i]};
			MEM_LBU: return {24'h0, model[i]};
			MEM_LH: return {{16{model[i+1][7]}}, model[i+1], model[i]};
			MEM_LHU: return {16'h0, model[i+1], model[i]};
			MEM_LW: return {model[i+3], model[i+2], model[i+1], model[i]};
			default: return '1;
		endcase
	endfunction

	function automatic void model_store(input mem_op_t op, input word_t addr, input word_t data);
		int i;
		i = byte_index(addr);
		case (op)
			MEM_SB: model[i] = data[7:0];
			MEM_SH: begin
				model[i] = data[7:0];
				model[i+1] = data[15:8];
			end
			MEM_SW: begin
				for (int b = 0; b < 4; b++) begin
					model[i+b] = data[8*b +: 8];
				end
			end
			default: ;
		endcase
	endfunction

	function automatic int total_errors();
		return errors + monitor_errors;
	endfunction

	// ##########################################################################
	// stimulus tasks called 1 ns after a rising edge
	// ##########################################################################

	task automatic check_value(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic exec(input mem_op_t op, input word_t addr, input word_t data);
		word_t pc;
		wb_sel_t wb;
		word_t expected;
		int n;
		bit done;
		if (!timed_out) begin
			pc = $urandom;
			wb = wb_sel_t'($urandom);
			expected = expected_load(op, addr);
			reg_pc = pc;
			rs2_data = data;
			alu_out = addr;
			mem_op = op;
			wb_sel = wb;
			n = 0;
			done = 1'b0;
			while (!done && n < WAIT_LIMIT) begin
				@(posedge clk);
				n++;
				done = next_flg === 1'b1;
				assert (is_stall === !next_flg) else begin
					$display("is_stall is not the inverse of next_flg");
					errors++;
				end
			end
			#1;
			mem_op = MEM_X;
			if (!done) begin
				$display("timeout: next_flg did not rise within %0d cycles", WAIT_LIMIT);
				errors++;
				timed_out = 1'b1;
			end else begin
				check_value("out_reg_pc", out_reg_pc, pc);
				check_value("out_alu_out", out_alu_out, addr);
				check_value("out_wb_sel", word_t'(out_wb_sel), word_t'(wb));
				if (op == MEM_X) begin
					assert (n == 1) else begin
						$display("non-memory instruction stalled for %0d cycles", n - 1);
						errors++;
					end
				end else begin
					assert (n >= 3) else begin
						$display("memory instruction finished without stalling");
						errors++;
					end
				end
				if (op inside {MEM_SB, MEM_SH, MEM_SW}) begin
					model_store(op, addr, data);
					store_total++;
				end else begin
					check_value("read_data", read_data, expected);
					if (op != MEM_X) begin
						load_total++;
					end
				end
			end
		end
	endtask

	task automatic write_cfg(input cfg_addr_t addr, input count_t value);
		cfg_we = 1'b1;
		cfg_addr = addr;
		cfg_wdata = value;
		@(posedge clk);
		#1;
		cfg_we = 1'b0;
	endtask

	task automatic read_cfg(input cfg_addr_t addr, output count_t value);
		cfg_addr = addr;
		@(posedge clk);
		value = cfg_rdata;
		#1;
	endtask

	// waits until the controller has finished its last access.
	task automatic settle();
		int n;
		if (!timed_out) begin
			n = 0;
			while (u_dut.cmd_ready !== 1'b1 && n < WAIT_LIMIT) begin
				@(posedge clk);
				#1;
				n++;
			end
			if (u_dut.cmd_ready !== 1'b1) begin
				$display("timeout: cmd_ready did not return within %0d cycles", WAIT_LIMIT);
				errors++;
				timed_out = 1'b1;
			end
			repeat (2) @(posedge clk);
			#1;
		end
	endtask

	task automatic check_counters();
		count_t value;
		settle();
		read_cfg(CFG_LOAD_COUNT, value);
		check_value("load_count", word_t'(value), word_t'(load_total));
		read_cfg(CFG_STORE_COUNT, value);
		check_value("store_count", word_t'(value), word_t'(store_total));
	endtask

	task automatic end_test(input int num, input string name, input int start);
		if (total_errors() == start) begin
			tests_passed++;
			$display("test %0d %s: pass", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: fail, %0d failed checks", num, name, total_errors() - start);
		end
	endtask

	// ##########################################################################
	// test sequence
	// ##########################################################################

	initial begin
		int start;
		int rw;
		int ww;
		count_t value;
		word_t addr;
		word_t data;
		mem_op_t op;
		void'($urandom(SEED));
		rst = 1'b1;
		reg_pc = '0;
		rs2_data = '0;
		alu_out = '0;
		mem_op = MEM_X;
		wb_sel = '0;
		cfg_we = 1'b0;
		cfg_addr = CFG_READ_WAIT;
		cfg_wdata = '0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		start = total_errors();
		read_cfg(CFG_READ_WAIT, value);
		check_value("read_wait", word_t'(value), 32'd1);
		read_cfg(CFG_WRITE_WAIT, value);
		check_value("write_wait", word_t'(value), 32'd1);
		read_cfg(CFG_LOAD_COUNT, value);
		check_value("load_count", word_t'(value), 32'd0);
		read_cfg(CFG_STORE_COUNT, value);
		check_value("store_count", word_t'(value), 32'd0);
		check_value("next_flg", word_t'(next_flg), 32'd1);
		end_test(1, "reset state", start);

		start = total_errors();
		repeat (8) exec(MEM_X, $urandom, $urandom);
		end_test(2, "non-memory passthrough", start);

		// every word is written once so that no load returns unknown data.
		start = total_errors();
		for (int i = 0; i < RAM_WORDS; i++) begin
			exec(MEM_SW, word_t'(i * 4), fill_word(word_t'(i * 4)));
		end
		repeat (8) begin
			addr = $urandom & 32'hFFFF_FFFC;
			exec(MEM_SW, addr, $urandom);
			exec(MEM_LW, addr, '0);
		end
		end_test(3, "word store and load", start);

		start = total_errors();
		for (int k = 0; k < 2; k++) begin
			addr = $urandom & 32'hFFFF_FFFC;
			for (int lane = 0; lane < 4; lane++) begin
				data = $urandom;
				data[7] = lane[0] ^ k[0];
				exec(MEM_SB, addr + word_t'(lane), data);
				exec(MEM_LW, addr, '0);
			end
			for (int lane = 0; lane < 4; lane += 2) begin
				data = $urandom;
				data[15] = lane[1] ^ k[0];
				exec(MEM_SH, addr + word_t'(lane), data);
				exec(MEM_LW, addr, '0);
			end
			for (int lane = 0; lane < 4; lane++) begin
				exec(MEM_LB, addr + word_t'(lane), '0);
				exec(MEM_LBU, addr + word_t'(lane), '0);
				if (lane[0] == 1'b0) begin
					exec(MEM_LH, addr + word_t'(lane), '0);
					exec(MEM_LHU, addr + word_t'(lane), '0);
				end
			end
		end
		end_test(4, "sub-word accesses", start);

		start = total_errors();
		for (int round = 0; round < 4; round++) begin
			rw = int'($urandom % 16);
			ww = int'($urandom % 16);
			settle();
			write_cfg(CFG_READ_WAIT, count_t'(rw));
			write_cfg(CFG_WRITE_WAIT, count_t'(ww));
			cur_read_wait = rw;
			read_cfg(CFG_READ_WAIT, value);
			check_value("read_wait", word_t'(value), word_t'(rw));
			read_cfg(CFG_WRITE_WAIT, value);
			check_value("write_wait", word_t'(value), word_t'(ww));
			repeat (4) begin
				addr = $urandom & 32'hFFFF_FFFC;
				exec(MEM_SW, addr, $urandom);
				op = mem_op_t'(32'd1 + $urandom % 5);
				exec(op, aligned_addr(op, addr + ($urandom & 32'd3)), '0);
			end
			check_counters();
		end
		end_test(5, "configurable wait states", start);

		// full 32-bit addresses also exercise the wrap at the end of the RAM.
		start = total_errors();
		for (int i = 0; i < 200; i++) begin
			op = mem_op_t'($urandom % 9);
			exec(op, aligned_addr(op, $urandom), $urandom);
		end
		check_counters();
		end_test(6, "random traffic", start);

		$display("tests passed %0d, tests failed %0d, failed checks %0d",
			tests_passed, tests_failed, total_errors());
		if (total_errors() == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== src/mem_subsystem.sv ====
`timescale 1ns/100ps

module mem_subsystem #(
	parameter int RAM_WORDS = 256
) (
	input logic clk,
	input logic rst,

	input core_pkg::word_t reg_pc,
	input core_pkg::word_t rs2_data,
	input core_pkg::word_t alu_out,
	input core_pkg::mem_op_t mem_op,
	input core_pkg::wb_sel_t wb_sel,

	output core_pkg::word_t read_data,
	output core_pkg::word_t out_reg_pc,
	output core_pkg::word_t out_alu_out,
	output core_pkg::wb_sel_t out_wb_sel,
	output logic next_flg,
	output logic is_stall,

	input logic cfg_we,
	input mem_pkg::cfg_addr_t cfg_addr,
	input mem_pkg::count_t cfg_wdata,
	output mem_pkg::count_t cfg_rdata
);
	import core_pkg::*;
	import mem_pkg::*;

	localparam int IDX_W = $clog2(RAM_WORDS);

	// ##########################################################################
	// stage to controller command path
	// ##########################################################################

	mem_cmd_t cmd;
	logic cmd_ready;
	word_t mem_addr;
	word_t mem_wdata;
	byte_mask_t mem_mask;
	word_t mem_rdata;
	logic rdata_valid;

	wait_t read_wait;
	wait_t write_wait;
	logic load_done;
	logic store_done;

	logic ram_en;
	logic ram_we;
	logic [IDX_W-1:0] ram_index;
	byte_mask_t ram_wmask;
	word_t ram_wdata;
	word_t ram_rdata;

	memory_stage u_stage (
		.clk(clk),
		.rst(rst),
		.reg_pc(reg_pc),
		.rs2_data(rs2_data),
		.alu_out(alu_out),
		.mem_op(mem_op),
		.wb_sel(wb_sel),
		.read_data(read_data),
		.out_reg_pc(out_reg_pc),
		.out_alu_out(out_alu_out),
		.out_wb_sel(out_wb_sel),
		.next_flg(next_flg),
		.is_stall(is_stall),
		.cmd(cmd),
		.cmd_ready(cmd_ready),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_mask(mem_mask),
		.mem_rdata(mem_rdata),
		.rdata_valid(rdata_valid)
	);

	mem_controller #(
		.RAM_WORDS(RAM_WORDS)
	) u_ctrl (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_mask(mem_mask),
		.cmd_ready(cmd_ready),
		.mem_rdata(mem_rdata),
		.rdata_valid(rdata_valid),
		.read_wait(read_wait),
		.write_wait(write_wait),
		.load_done(load_done),
		.store_done(store_done),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.ram_index(ram_index),
		.ram_wmask(ram_wmask),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata)
	);

	mem_timing_regs u_timing (
		.clk(clk),
		.rst(rst),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.read_wait(read_wait),
		.write_wait(write_wait),
		.load_done(load_done),
		.store_done(store_done)
	);

	data_ram #(
		.RAM_WORDS(RAM_WORDS)
	) u_ram (
		.clk(clk),
		.en(ram_en),
		.we(ram_we),
		.index(ram_index),
		.wmask(ram_wmask),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

endmodule

// ==== src/mem_timing_regs.sv ====
`timescale 1ns/100ps

module mem_timing_regs (
	input logic clk,
	input logic rst,

	input logic cfg_we,
	input mem_pkg::cfg_addr_t cfg_addr,
	input mem_pkg::count_t cfg_wdata,
	output mem_pkg::count_t cfg_rdata,

	output mem_pkg::wait_t read_wait,
	output mem_pkg::wait_t write_wait,
	input logic load_done,
	input logic store_done
);
	import mem_pkg::*;

	count_t load_count;
	count_t store_count;

	always_ff @(posedge clk) begin
		if (rst) begin
			read_wait <= wait_t'(1);
			write_wait <= wait_t'(1);
			load_count <= '0;
			store_count <= '0;
		end else begin
			if (cfg_we && cfg_addr == CFG_READ_WAIT) begin
				read_wait <= cfg_wdata[$bits(wait_t)-1:0];
			end
			if (cfg_we && cfg_addr == CFG_WRITE_WAIT) begin
				write_wait <= cfg_wdata[$bits(wait_t)-1:0];
			end
			// the counters stop at their maximum instead of wrapping.
			if (load_done && load_count != '1) begin
				load_count <= load_count + 1'b1;
			end
			if (store_done && store_count != '1) begin
				store_count <= store_count + 1'b1;
			end
		end
	end

	always_comb begin
		case (cfg_addr)
			CFG_READ_WAIT: cfg_rdata = count_t'(read_wait);
			CFG_WRITE_WAIT: cfg_rdata = count_t'(write_wait);
			CFG_LOAD_COUNT: cfg_rdata = load_count;
			default: cfg_rdata = store_count;
		endcase
	end

endmodule

// ==== src/data_ram.sv ====
`timescale 1ns/100ps

module data_ram #(
	parameter int RAM_WORDS = 256
) (
	input logic clk,

	input logic en,
	input logic we,
	input logic [$clog2(RAM_WORDS)-1:0] index,
	input mem_pkg::byte_mask_t wmask,
	input core_pkg::word_t wdata,
	output core_pkg::word_t rdata
);
	import core_pkg::*;

	word_t mem [RAM_WORDS];

	// ##########################################################################
	// single port with one access per enabled cycle
	// ##########################################################################

	// a write leaves rdata unchanged, so the last read result stays valid
	// while the controller waits.
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				for (int b = 0; b < 4; b++) begin
					if (wmask[b]) begin
						mem[index][8*b +: 8] <= wdata[8*b +: 8];
					end
				end
			end else begin
				rdata <= mem[index];
			end
		end
	end

endmodule

// ==== src/mem_controller.sv ====
`timescale 1ns/100ps

module mem_controller #(
	parameter int RAM_WORDS = 256
) (
	input logic clk,
	input logic rst,

	input mem_pkg::mem_cmd_t cmd,
	input core_pkg::word_t mem_addr,
	input core_pkg::word_t mem_wdata,
	input mem_pkg::byte_mask_t mem_mask,
	output logic cmd_ready,
	output core_pkg::word_t mem_rdata,
	output logic rdata_valid,

	input mem_pkg::wait_t read_wait,
	input mem_pkg::wait_t write_wait,
	output logic load_done,
	output logic store_done,

	output logic ram_en,
	output logic ram_we,
	output logic [$clog2(RAM_WORDS)-1:0] ram_index,
	output mem_pkg::byte_mask_t ram_wmask,
	output core_pkg::word_t ram_wdata,
	input core_pkg::word_t ram_rdata
);
	import core_pkg::*;
	import mem_pkg::*;

	localparam int IDX_W = $clog2(RAM_WORDS);

	typedef enum logic [1:0] {
		READY,
		READ_WAIT,
		WRITE_WAIT
	} state_t;

	state_t state;
	wait_t wait_cnt;
	word_t word_addr;
	logic accept;

	assign cmd_ready = state == READY;
	assign accept = state == READY && cmd != CMD_NOP;

	// the byte address becomes a word index that wraps at the end of the RAM.
	assign word_addr = {2'b00, mem_addr[31:2]};
	assign ram_index = IDX_W'(word_addr % RAM_WORDS);

	// the RAM is accessed at the edge that accepts the command.
	assign ram_en = accept;
	assign ram_we = accept && cmd == CMD_WRITE;
	assign ram_wmask = mem_mask;
	assign ram_wdata = mem_wdata;

	// the RAM output holds until the next enabled read.
	assign mem_rdata = ram_rdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= READY;
			wait_cnt <= '0;
			rdata_valid <= 1'b0;
			load_done <= 1'b0;
			store_done <= 1'b0;
		end else begin
			rdata_valid <= 1'b0;
			load_done <= 1'b0;
			store_done <= 1'b0;
			case (state)
				READY: begin
					if (cmd == CMD_READ) begin
						state <= READ_WAIT;
						wait_cnt <= read_wait;
					end else if (cmd == CMD_WRITE) begin
						// zero write wait states keep the controller ready.
						if (write_wait == '0) begin
							store_done <= 1'b1;
						end else begin
							state <= WRITE_WAIT;
							wait_cnt <= write_wait - 1'b1;
						end
					end
				end
				READ_WAIT: begin
					if (wait_cnt == '0) begin
						rdata_valid <= 1'b1;
						load_done <= 1'b1;
						state <= READY;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				WRITE_WAIT: begin
					if (wait_cnt == '0) begin
						store_done <= 1'b1;
						state <= READY;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				default: state <= READY;
			endcase
		end
	end

endmodule

// ==== src/memory_stage.sv ====
`timescale 1ns/100ps

module memory_stage (
	input logic clk,
	input logic rst,

	input core_pkg::word_t reg_pc,
	input core_pkg::word_t rs2_data,
	input core_pkg::word_t alu_out,
	input core_pkg::mem_op_t mem_op,
	input core_pkg::wb_sel_t wb_sel,

	output core_pkg::word_t read_data,
	output core_pkg::word_t out_reg_pc,
	output core_pkg::word_t out_alu_out,
	output core_pkg::wb_sel_t out_wb_sel,
	output logic next_flg,
	output logic is_stall,

	output mem_pkg::mem_cmd_t cmd,
	input logic cmd_ready,
	output core_pkg::word_t mem_addr,
	output core_pkg::word_t mem_wdata,
	output mem_pkg::byte_mask_t mem_mask,
	input core_pkg::word_t mem_rdata,
	input logic rdata_valid
);
	import core_pkg::*;
	import mem_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_READY,
		WAIT_VALID,
		DONE
	} state_t;

	state_t state;

	// the accepted instruction is held here until its access has finished.
	word_t save_reg_pc;
	word_t save_rs2_data;
	word_t save_alu_out;
	mem_op_t save_mem_op;
	wb_sel_t save_wb_sel;

	logic is_store;
	logic [1:0] lane;
	word_t store_wdata;
	byte_mask_t store_mask;
	word_t byte_lane;
	word_t half_lane;
	word_t load_data;

	assign next_flg = (state == IDLE && mem_op == MEM_X) || state == DONE;
	assign is_stall = ~next_flg;

	assign lane = save_alu_out[1:0];
	assign is_store = save_mem_op inside {MEM_SB, MEM_SH, MEM_SW};

	// ##########################################################################
	// store lane placement
	// ##########################################################################

	// halfwords use only the upper address bit, so a halfword never straddles
	// the word boundary.
	always_comb begin
		case (save_mem_op)
			MEM_SB: begin
				store_wdata = word_t'(save_rs2_data[7:0]) << {lane, 3'b000};
				store_mask = 4'b0001 << lane;
			end
			MEM_SH: begin
				store_wdata = word_t'(save_rs2_data[15:0]) << {lane[1], 4'b0000};
				store_mask = 4'b0011 << {lane[1], 1'b0};
			end
			default: begin
				store_wdata = save_rs2_data;
				store_mask = 4'b1111;
			end
		endcase
	end

	// ##########################################################################
	// load lane extraction
	// ##########################################################################

	assign byte_lane = mem_rdata >> {lane, 3'b000};
	assign half_lane = mem_rdata >> {lane[1], 4'b0000};

	always_comb begin
		case (save_mem_op)
			MEM_LB: load_data = {{24{byte_lane[7]}}, byte_lane[7:0]};
			MEM_LBU: load_data = {24'b0, byte_lane[7:0]};
			MEM_LH: load_data = {{16{half_lane[15]}}, half_lane[15:0]};
			MEM_LHU: load_data = {16'b0, half_lane[15:0]};
			MEM_LW: load_data = mem_rdata;
			default: load_data = '1;
		endcase
	end

	// the command is a single-cycle pulse that falls back to nop every cycle
	// unless a new access is issued.
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			cmd <= CMD_NOP;
		end else begin
			cmd <= CMD_NOP;
			case (state)
				IDLE: begin
					if (mem_op != MEM_X) begin
						state <= WAIT_READY;
					end
				end
				WAIT_READY: begin
					if (cmd_ready) begin
						if (is_store) begin
							cmd <= CMD_WRITE;
							state <= DONE;
						end else begin
							cmd <= CMD_READ;
							state <= WAIT_VALID;
						end
					end
				end
				WAIT_VALID: begin
					if (rdata_valid) begin
						state <= DONE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (mem_op == MEM_X) begin
					read_data <= '1;
					out_reg_pc <= reg_pc;
					out_alu_out <= alu_out;
					out_wb_sel <= wb_sel;
				end else begin
					save_reg_pc <= reg_pc;
					save_rs2_data <= rs2_data;
					save_alu_out <= alu_out;
					save_mem_op <= mem_op;
					save_wb_sel <= wb_sel;
				end
			end
			WAIT_READY: begin
				if (cmd_ready) begin
					mem_addr <= save_alu_out;
					mem_wdata <= store_wdata;
					mem_mask <= store_mask;
				end
			end
			WAIT_VALID: begin
				if (rdata_valid) begin
					read_data <= load_data;
				end
			end
			default: begin
				out_reg_pc <= save_reg_pc;
				out_alu_out <= save_alu_out;
				out_wb_sel <= save_wb_sel;
			end
		endcase
	end

endmodule

// ==== src/mem_pkg.sv ====
package mem_pkg;

	// the memory stage holds a command for a single cycle.
	typedef enum logic [2:0] {
		CMD_NOP,
		CMD_READ,
		CMD_WRITE
	} mem_cmd_t;

	// each byte lane has one enable bit and bit 0 is the lowest address.
	typedef logic [3:0] byte_mask_t;

	// number of extra cycles an access waits before it completes.
	typedef logic [3:0] wait_t;

	// width of the access counters and of the config data path.
	typedef logic [15:0] count_t;

	// ##########################################################################
	// config register map
	// ##########################################################################

	typedef logic [1:0] cfg_addr_t;

	localparam cfg_addr_t CFG_READ_WAIT = 2'd0;
	localparam cfg_addr_t CFG_WRITE_WAIT = 2'd1;

	// the counters are read only.
	localparam cfg_addr_t CFG_LOAD_COUNT = 2'd2;
	localparam cfg_addr_t CFG_STORE_COUNT = 2'd3;

endpackage

// ==== src/core_pkg.sv ====
package core_pkg;

	// ##########################################################################
	// pipeline data words
	// ##########################################################################

	// a data word or a byte address.
	typedef logic [31:0] word_t;

	// selects the writeback source in the later stage. it is not decoded here.
	typedef logic [3:0] wb_sel_t;

	// ##########################################################################
	// memory operation codes
	// ##########################################################################

	typedef logic [4:0] mem_op_t;

	// the instruction makes no memory access and only passes through.
	localparam mem_op_t MEM_X = 5'd0;

	// loads.
	localparam mem_op_t MEM_LB = 5'd1;
	localparam mem_op_t MEM_LBU = 5'd2;
	localparam mem_op_t MEM_LH = 5'd3;
	localparam mem_op_t MEM_LHU = 5'd4;
	localparam mem_op_t MEM_LW = 5'd5;

	// stores.
	localparam mem_op_t MEM_SB = 5'd6;
	localparam mem_op_t MEM_SH = 5'd7;
	localparam mem_op_t MEM_SW = 5'd8;

endpackage
